// ==== verilog/rename_pkg.sv ====
// Shared widths plus register, tag, data and interface struct types of the renaming core
`default_nettype none

package rename_pkg;

    // Operand width and architectural register file size
    localparam int DATA_WIDTH = 32;
    localparam int REG_COUNT  = 32;

    // Four tag bits cover every supported ROB depth (4, 8 or 16)
    localparam int TAG_WIDTH  = 4;

    typedef logic [DATA_WIDTH-1:0]        data_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
    typedef logic [TAG_WIDTH-1:0]         tag_t;

    // Instruction as seen by the rename stage
    typedef struct packed {
        reg_idx_t rdest;
        logic     has_dest;
        reg_idx_t rsrc0;
        reg_idx_t rsrc1;
    } disp_op_t;

    // A source is either a value (rdy set) or the tag of its producer
    typedef struct packed {
        logic  rdy;
        tag_t  tag;
        data_t data;
    } operand_t;

    typedef struct packed {
        tag_t     tag;
        operand_t src0;
        operand_t src1;
    } disp_res_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
    } cmpl_t;

    typedef struct packed {
        reg_idx_t rdest;
        logic     has_dest;
        tag_t     tag;
        data_t    data;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/register_map.sv ====
// Architectural register map holding committed value, newest producer tag and ready bit
`timescale 1ns/1ps
`default_nettype none

module register_map import rename_pkg::*; (
    input  logic     clk,
    input  logic     n_rst,

    // Flush discards every in-flight producer
    input  logic     i_flush,

    // Commit from the ROB
    input  logic     i_retire_valid,
    input  retire_t  i_retire,

    // New producer for a destination register
    input  logic     i_rename_en,
    input  reg_idx_t i_rename_rdest,
    input  tag_t     i_rename_tag,

    // Two source lookups answered in the same cycle
    input  reg_idx_t i_lookup_rsrc0,
    input  reg_idx_t i_lookup_rsrc1,
    output operand_t o_lookup_op0,
    output operand_t o_lookup_op1
);

    // Committed value, newest producer tag and ready bit of every register
    data_t                data_q [REG_COUNT];
    tag_t                 tag_q  [REG_COUNT];
    logic [REG_COUNT-1:0] rdy_q;

    logic                 rename_wr;
    logic                 retire_wr;

    // Writes to r0 are dropped because the result of such an instruction is thrown away
    assign rename_wr = i_rename_en && (i_rename_rdest != '0);
    assign retire_wr = i_retire_valid && i_retire.has_dest && (i_retire.rdest != '0);

    // Combinational read of one map entry
    function automatic operand_t read_entry(input reg_idx_t idx);
        operand_t op;
        op.rdy  = rdy_q[idx];
        op.tag  = tag_q[idx];
        op.data = data_q[idx];
        return op;
    endfunction

    assign o_lookup_op0 = read_entry(i_lookup_rsrc0);
    assign o_lookup_op1 = read_entry(i_lookup_rsrc1);

    // Tag follows every rename and data follows every commit
    // A commit still writes its value during a flush since it already left the ROB
    always_ff @(posedge clk) begin
        for (int i = 0; i < REG_COUNT; i++) begin
            if (i == 0) begin
                // r0 is pinned to zero with tag zero
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end else begin
                if (rename_wr && (i_rename_rdest == reg_idx_t'(i))) begin
                    tag_q[i] <= i_rename_tag;
                end
                if (retire_wr && (i_retire.rdest == reg_idx_t'(i))) begin
                    data_q[i] <= i_retire.data;
                end
            end
        end
    end

    // Ready bits give flush priority over rename and rename priority over retire
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rdy_q <= '1;
        end else begin
            for (int i = 0; i < REG_COUNT; i++) begin
                if (i == 0) begin
                    rdy_q[i] <= 1'b1;
                end else if (i_flush) begin
                    // Committed values are all that survive a flush
                    rdy_q[i] <= 1'b1;
                end else if (rename_wr && (i_rename_rdest == reg_idx_t'(i))) begin
                    // A newer producer wins over a commit in the same cycle
                    rdy_q[i] <= 1'b0;
                end else if (retire_wr && (i_retire.rdest == reg_idx_t'(i))) begin
                    // Only the newest producer of the register makes it ready again
                    if (i_retire.tag == tag_q[i]) begin
                        rdy_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // r0 must read as a ready zero on both ports at all times after reset
    a_r0_zero_op0: assert property (@(posedge clk) disable iff (!n_rst)
        (i_lookup_rsrc0 == '0) |-> (o_lookup_op0.rdy && (o_lookup_op0.data == '0)));

    a_r0_zero_op1: assert property (@(posedge clk) disable iff (!n_rst)
        (i_lookup_rsrc1 == '0) |-> (o_lookup_op1.rdy && (o_lookup_op1.data == '0)));

endmodule

`default_nettype wire

// ==== verilog/reorder_buffer.sv ====
// Reorder buffer with tag allocation, completion capture, in-order retire and bypass probes
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import rename_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic     clk,
    input  logic     n_rst,
    input  logic     i_flush,

    // Allocation at the tail with a combinational tag and full flag
    input  logic     i_alloc_en,
    input  disp_op_t i_alloc_op,
    output tag_t     o_alloc_tag,
    output logic     o_full,

    // Result bus carrying a one-cycle pulse
    input  logic     i_cmpl_valid,
    input  cmpl_t    i_cmpl,

    // Operand bypass probes
    input  tag_t     i_probe_tag0,
    input  tag_t     i_probe_tag1,
    output logic     o_probe_done0,
    output logic     o_probe_done1,
    output data_t    o_probe_data0,
    output data_t    o_probe_data1,

    // Registered commit of the oldest entry
    output logic     o_retire_valid,
    output retire_t  o_retire
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    // Payload of one entry
    typedef struct packed {
        reg_idx_t rdest;
        logic     has_dest;
        data_t    data;
    } rob_payload_t;

    // Tags index entries directly, so the depth must fit in the tag width
    if (ROB_DEPTH > (2 ** TAG_WIDTH)) begin : g_depth_check
        $error("ROB depth does not fit in the tag width");
    end

    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] done_q;
    rob_payload_t         payload_q [ROB_DEPTH];
    ptr_t                 head_q;
    ptr_t                 tail_q;
    logic [PTR_W:0]       count_q;

    logic                 retire_valid_q;
    retire_t              retire_q;

    logic                 alloc;
    logic                 pop;
    ptr_t                 cmpl_ptr;

    assign o_full      = (count_q == (PTR_W + 1)'(ROB_DEPTH));
    assign o_alloc_tag = tag_t'(tail_q);
    assign cmpl_ptr    = i_cmpl.tag[PTR_W-1:0];

    // Flush blocks both ends of the queue in its cycle
    assign alloc = i_alloc_en && !o_full && !i_flush;
    assign pop   = valid_q[head_q] && done_q[head_q] && !i_flush;

    // An entry popped last cycle sits in the retire register until the map has it,
    // so a probe of that tag is answered from there
    function automatic logic probe_done(input tag_t t);
        return (valid_q[t[PTR_W-1:0]] && done_q[t[PTR_W-1:0]]) ||
               (retire_valid_q && (retire_q.tag == t));
    endfunction

    function automatic data_t probe_data(input tag_t t);
        if (retire_valid_q && (retire_q.tag == t)) begin
            return retire_q.data;
        end
        return payload_q[t[PTR_W-1:0]].data;
    endfunction

    assign o_probe_done0 = probe_done(i_probe_tag0);
    assign o_probe_done1 = probe_done(i_probe_tag1);
    assign o_probe_data0 = probe_data(i_probe_tag0);
    assign o_probe_data1 = probe_data(i_probe_tag1);

    assign o_retire_valid = retire_valid_q;
    assign o_retire       = retire_q;

    // Queue control state
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            valid_q        <= '0;
            done_q         <= '0;
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            retire_valid_q <= 1'b0;
        end else if (i_flush) begin
            // Empty the queue and let allocation carry on from the current tail
            valid_q        <= '0;
            done_q         <= '0;
            head_q         <= tail_q;
            count_q        <= '0;
            retire_valid_q <= 1'b0;
        end else begin
            if (alloc) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + ptr_t'(1);
            end
            if (i_cmpl_valid) begin
                done_q[cmpl_ptr] <= 1'b1;
            end
            // Pop comes last so that it frees the head entry outright
            if (pop) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
                head_q          <= head_q + ptr_t'(1);
            end
            count_q        <= count_q + (PTR_W + 1)'(alloc) - (PTR_W + 1)'(pop);
            retire_valid_q <= pop;
        end
    end

    // Entry payload and the retire register
    always_ff @(posedge clk) begin
        if (alloc) begin
            payload_q[tail_q].rdest    <= i_alloc_op.rdest;
            payload_q[tail_q].has_dest <= i_alloc_op.has_dest;
        end
        if (i_cmpl_valid) begin
            payload_q[cmpl_ptr].data <= i_cmpl.data;
        end
        if (pop) begin
            retire_q.rdest    <= payload_q[head_q].rdest;
            retire_q.has_dest <= payload_q[head_q].has_dest;
            retire_q.tag      <= tag_t'(head_q);
            retire_q.data     <= payload_q[head_q].data;
        end
    end

    // The dispatcher must hold off while the queue is full
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full);

    // Results only come back for instructions still in the queue
    a_cmpl_valid_entry: assert property (@(posedge clk) disable iff (!n_rst)
        i_cmpl_valid |-> valid_q[cmpl_ptr]);

endmodule

`default_nettype wire

// ==== verilog/dispatch_ctrl.sv ====
// Dispatch handshake FSM with rename write and source operand resolution
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl import rename_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      i_flush,

    // Four-phase req/ack dispatch port
    input  logic      i_disp_req,
    input  disp_op_t  i_disp_op,
    output logic      o_disp_ack,
    output disp_res_t o_disp_res,

    // ROB allocation
    input  logic      i_rob_full,
    input  tag_t      i_alloc_tag,
    output logic      o_alloc_en,
    output logic      o_rename_en,

    // Register map lookup
    output reg_idx_t  o_lookup_rsrc0,
    output reg_idx_t  o_lookup_rsrc1,
    input  operand_t  i_map_op0,
    input  operand_t  i_map_op1,

    // ROB bypass probes
    output tag_t      o_probe_tag0,
    output tag_t      o_probe_tag1,
    input  logic      i_probe_done0,
    input  logic      i_probe_done1,
    input  data_t     i_probe_data0,
    input  data_t     i_probe_data1
);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } state_t;

    state_t    state_q;
    disp_res_t res_q;

    // A source that is pending in the map but already done in the ROB becomes a value
    function automatic operand_t merge_operand(input operand_t map_op, input logic done,
                                               input data_t data);
        operand_t op;
        op = map_op;
        if (!map_op.rdy) begin
            op.rdy  = done;
            op.data = done ? data : '0;
        end
        return op;
    endfunction

    // Sources are looked up before this instruction renames its own rdest
    assign o_lookup_rsrc0 = i_disp_op.rsrc0;
    assign o_lookup_rsrc1 = i_disp_op.rsrc1;
    assign o_probe_tag0   = i_map_op0.tag;
    assign o_probe_tag1   = i_map_op1.tag;

    // One allocation per request, taken on the edge that raises ack
    assign o_alloc_en  = (state_q == ST_IDLE) && i_disp_req && !i_rob_full && !i_flush;
    assign o_rename_en = o_alloc_en && i_disp_op.has_dest && (i_disp_op.rdest != '0);

    assign o_disp_ack = (state_q == ST_ACK);
    assign o_disp_res = res_q;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (o_alloc_en) state_q <= ST_ACK;
                // Ack drops one edge after req is seen low
                ST_ACK:  if (!i_disp_req) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Answer is only meaningful while ack is high
    always_ff @(posedge clk) begin
        if (o_alloc_en) begin
            res_q.tag  <= i_alloc_tag;
            res_q.src0 <= merge_operand(i_map_op0, i_probe_done0, i_probe_data0);
            res_q.src1 <= merge_operand(i_map_op1, i_probe_done1, i_probe_data1);
        end
    end

    // The allocated tag always names a real ROB entry
    if (ROB_DEPTH > (2 ** TAG_WIDTH)) begin : g_depth_check
        $error("ROB depth does not fit in the tag width");
    end

    // Source may only drop req once ack has been seen
    a_req_held: assert property (@(posedge clk) disable iff (!n_rst)
        $fell(i_disp_req) |-> $past(o_disp_ack));

endmodule

`default_nettype wire

// ==== verilog/rename_core.sv ====
// Rename core top level joining dispatch control, reorder buffer and register map
`timescale 1ns/1ps
`default_nettype none

module rename_core import rename_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      i_flush,

    input  logic      i_disp_req,
    input  disp_op_t  i_disp_op,
    output logic      o_disp_ack,
    output disp_res_t o_disp_res,

    input  logic      i_cmpl_valid,
    input  cmpl_t     i_cmpl,

    output logic      o_retire_valid,
    output retire_t   o_retire
);

    localparam int ROB_DEPTH = 8;

    // Dispatch to ROB and map
    logic     alloc_en;
    logic     rename_en;
    logic     rob_full;
    tag_t     alloc_tag;

    // Lookup and bypass
    reg_idx_t lookup_rsrc0;
    reg_idx_t lookup_rsrc1;
    operand_t map_op0;
    operand_t map_op1;
    tag_t     probe_tag0;
    tag_t     probe_tag1;
    logic     probe_done0;
    logic     probe_done1;
    data_t    probe_data0;
    data_t    probe_data1;

    dispatch_ctrl #(
        .ROB_DEPTH (ROB_DEPTH)
    ) i_dispatch_ctrl (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_disp_req     (i_disp_req),
        .i_disp_op      (i_disp_op),
        .o_disp_ack     (o_disp_ack),
        .o_disp_res     (o_disp_res),
        .i_rob_full     (rob_full),
        .i_alloc_tag    (alloc_tag),
        .o_alloc_en     (alloc_en),
        .o_rename_en    (rename_en),
        .o_lookup_rsrc0 (lookup_rsrc0),
        .o_lookup_rsrc1 (lookup_rsrc1),
        .i_map_op0      (map_op0),
        .i_map_op1      (map_op1),
        .o_probe_tag0   (probe_tag0),
        .o_probe_tag1   (probe_tag1),
        .i_probe_done0  (probe_done0),
        .i_probe_done1  (probe_done1),
        .i_probe_data0  (probe_data0),
        .i_probe_data1  (probe_data1)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) i_reorder_buffer (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_alloc_en     (alloc_en),
        .i_alloc_op     (i_disp_op),
        .o_alloc_tag    (alloc_tag),
        .o_full         (rob_full),
        .i_cmpl_valid   (i_cmpl_valid),
        .i_cmpl         (i_cmpl),
        .i_probe_tag0   (probe_tag0),
        .i_probe_tag1   (probe_tag1),
        .o_probe_done0  (probe_done0),
        .o_probe_done1  (probe_done1),
        .o_probe_data0  (probe_data0),
        .o_probe_data1  (probe_data1),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire)
    );

    // Rename uses the same tag the ROB hands out on this alloc pulse
    register_map i_register_map (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_retire_valid (o_retire_valid),
        .i_retire       (o_retire),
        .i_rename_en    (rename_en),
        .i_rename_rdest (i_disp_op.rdest),
        .i_rename_tag   (alloc_tag),
        .i_lookup_rsrc0 (lookup_rsrc0),
        .i_lookup_rsrc1 (lookup_rsrc1),
        .o_lookup_op0   (map_op0),
        .o_lookup_op1   (map_op1)
    );

endmodule

`default_nettype wire

// ==== verif/tb_rename_core.sv ====
// Testbench for the rename core with pattern reader, reference model, compare tasks and timeouts
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core import rename_pkg::*; ();

    localparam int ROB_DEPTH = 8;
    localparam int TIMEOUT   = 100;

    logic      clk;
    logic      n_rst;
    logic      flush;
    logic      disp_req;
    disp_op_t  disp_op;
    logic      disp_ack;
    disp_res_t disp_res;
    logic      cmpl_valid;
    cmpl_t     cmpl;
    logic      retire_valid;
    retire_t   retire;

    // Reference register map
    data_t     m_data [REG_COUNT];
    tag_t      m_tag  [REG_COUNT];
    logic      m_rdy  [REG_COUNT];

    // Reference ROB, indexed by tag
    logic      rob_valid [ROB_DEPTH];
    logic      rob_done  [ROB_DEPTH];
    disp_op_t  rob_op    [ROB_DEPTH];
    data_t     rob_data  [ROB_DEPTH];
    int        rob_head;
    int        rob_tail;

    disp_op_t  req_op;
    retire_t   retired_q[$];
    retire_t   model_retire_q[$];

    rename_core i_rename_core (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (flush),
        .i_disp_req     (disp_req),
        .i_disp_op      (disp_op),
        .o_disp_ack     (disp_ack),
        .o_disp_res     (disp_res),
        .i_cmpl_valid   (cmpl_valid),
        .i_cmpl         (cmpl),
        .o_retire_valid (retire_valid),
        .o_retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Every commit the DUT makes is queued here and matched later in order
    always @(negedge clk) begin
        if (n_rst && retire_valid) begin
            retired_q.push_back(retire);
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_disp_res(input disp_res_t got, input disp_res_t exp);
        disp_res_t got_cmp;
        disp_res_t exp_cmp;
        got_cmp = got;
        exp_cmp = exp;
        // Only a pending operand has a meaningful tag
        if (exp.src0.rdy) begin
            got_cmp.src0.tag = '0;
            exp_cmp.src0.tag = '0;
        end
        if (exp.src1.rdy) begin
            got_cmp.src1.tag = '0;
            exp_cmp.src1.tag = '0;
        end
        if (got_cmp !== exp_cmp) begin
            abort_run($sformatf("[ERROR] time %0t o_disp_res got %h expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_retire(input string name, input retire_t got, input retire_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] time %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic require_fields(input int code, input int need);
        if (code != need) begin
            abort_run("Pattern file line has the wrong number of fields");
        end
    endtask

    task automatic reset_reference();
        for (int i = 0; i < REG_COUNT; i++) begin
            m_data[i] = '0;
            m_tag[i]  = '0;
            m_rdy[i]  = 1'b1;
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_valid[i] = 1'b0;
            rob_done[i]  = 1'b0;
            rob_op[i]    = '0;
            rob_data[i]  = '0;
        end
        rob_head = 0;
        rob_tail = 0;
    endtask

    // Source value as the map and the finished ROB entries give it
    function automatic operand_t resolve_operand(input reg_idx_t r);
        operand_t op;
        int       slot;
        slot    = int'(m_tag[r]) % ROB_DEPTH;
        op.tag  = m_tag[r];
        op.rdy  = 1'b1;
        op.data = m_data[r];
        if (!m_rdy[r]) begin
            // A producer that already finished is forwarded as a value
            op.rdy  = rob_valid[slot] && rob_done[slot];
            op.data = op.rdy ? rob_data[slot] : '0;
        end
        return op;
    endfunction

    // Lookup happens before the instruction renames its own destination
    task automatic predict_dispatch(input disp_op_t op, output disp_res_t exp);
        exp.tag  = tag_t'(rob_tail);
        exp.src0 = resolve_operand(op.rsrc0);
        exp.src1 = resolve_operand(op.rsrc1);
        rob_valid[rob_tail] = 1'b1;
        rob_done[rob_tail]  = 1'b0;
        rob_op[rob_tail]    = op;
        if (op.has_dest && (op.rdest != '0)) begin
            m_tag[op.rdest] = tag_t'(rob_tail);
            m_rdy[op.rdest] = 1'b0;
        end
        rob_tail = (rob_tail + 1) % ROB_DEPTH;
    endtask

    task automatic record_completion(input tag_t t, input data_t d);
        retire_t ret;
        int      slot;
        slot = int'(t) % ROB_DEPTH;
        rob_done[slot] = 1'b1;
        rob_data[slot] = d;
        // Finished entries at the head leave in tag order
        while (rob_valid[rob_head] && rob_done[rob_head]) begin
            ret.rdest    = rob_op[rob_head].rdest;
            ret.has_dest = rob_op[rob_head].has_dest;
            ret.tag      = tag_t'(rob_head);
            ret.data     = rob_data[rob_head];
            model_retire_q.push_back(ret);
            if (ret.has_dest && (ret.rdest != '0)) begin
                m_data[ret.rdest] = ret.data;
                // Only the newest producer makes the register ready
                if (m_tag[ret.rdest] == ret.tag) begin
                    m_rdy[ret.rdest] = 1'b1;
                end
            end
            rob_valid[rob_head] = 1'b0;
            rob_done[rob_head]  = 1'b0;
            rob_head = (rob_head + 1) % ROB_DEPTH;
        end
    endtask

    task automatic flush_reference();
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_valid[i] = 1'b0;
            rob_done[i]  = 1'b0;
        end
        rob_head = rob_tail;
        for (int i = 0; i < REG_COUNT; i++) begin
            m_rdy[i] = 1'b1;
        end
    endtask

    function automatic disp_op_t make_op(input logic [31:0] rd, input logic [31:0] hd,
                                         input logic [31:0] s0, input logic [31:0] s1);
        disp_op_t op;
        op.rdest    = reg_idx_t'(rd);
        op.has_dest = hd[0];
        op.rsrc0    = reg_idx_t'(s0);
        op.rsrc1    = reg_idx_t'(s1);
        return op;
    endfunction

    task automatic raise_request(input disp_op_t op);
        @(posedge clk);
        disp_req <= 1'b1;
        disp_op  <= op;
        req_op = op;
    endtask

    // While the ROB is full the request must wait without an ack
    task automatic expect_stall(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (disp_ack !== 1'b0) begin
                abort_run($sformatf("[ERROR] time %0t o_disp_ack got %b expected 0",
                                    $time, disp_ack));
            end
        end
    endtask

    task automatic finish_handshake();
        disp_res_t exp;
        int        n;
        n = 0;
        @(negedge clk);
        while (!disp_ack && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (!disp_ack) begin
            abort_run("Dispatch request got no ack before the timeout");
        end
        predict_dispatch(req_op, exp);
        check_disp_res(disp_res, exp);
        @(posedge clk);
        disp_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (disp_ack && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (disp_ack) begin
            abort_run("Dispatch ack did not fall after the request was dropped");
        end
    endtask

    task automatic apply_completion(input tag_t t, input data_t d);
        @(posedge clk);
        cmpl_valid <= 1'b1;
        cmpl.tag   <= t;
        cmpl.data  <= d;
        @(posedge clk);
        cmpl_valid <= 1'b0;
        record_completion(t, d);
    endtask

    task automatic apply_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        flush_reference();
    endtask

    task automatic expect_retire(input retire_t exp);
        int n;
        n = 0;
        while ((retired_q.size() == 0) && (n < TIMEOUT)) begin
            @(posedge clk);
            n++;
        end
        if (retired_q.size() == 0) begin
            abort_run("Expected retirement did not happen before the timeout");
        end
        check_retire("o_retire", retired_q.pop_front(), exp);
        if (model_retire_q.size() == 0) begin
            abort_run("Reference model has no retirement pending for this line");
        end
        check_retire("model retire", model_retire_q.pop_front(), exp);
    endtask

    initial begin
        int           fd;
        int           code;
        bit           done;
        logic [7:0]   cmd;
        logic [1023:0] line;
        logic [31:0]  f0;
        logic [31:0]  f1;
        logic [31:0]  f2;
        logic [31:0]  f3;
        logic [31:0]  f4;
        retire_t      ret;

        n_rst      = 1'b0;
        flush      = 1'b0;
        disp_req   = 1'b0;
        disp_op    = '0;
        cmpl_valid = 1'b0;
        cmpl       = '0;
        done       = 1'b0;
        reset_reference();

        repeat (8) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        if (disp_ack !== 1'b0) begin
            abort_run($sformatf("[ERROR] time %0t o_disp_ack got %b expected 0", $time, disp_ack));
        end
        if (retire_valid !== 1'b0) begin
            abort_run($sformatf("[ERROR] time %0t o_retire_valid got %b expected 0",
                                $time, retire_valid));
        end

        fd = $fopen("verif/rename_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the pattern file verif/rename_patterns.txt");
        end

        // One command letter per line, followed by its hex fields
        while (!done) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "D") begin
                code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                require_fields(code, 4);
                raise_request(make_op(f0, f1, f2, f3));
                finish_handshake();
            end else if (cmd == "W") begin
                code = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                require_fields(code, 5);
                raise_request(make_op(f0, f1, f2, f3));
                expect_stall(int'(f4));
            end else if (cmd == "A") begin
                if (!disp_req) begin
                    abort_run("Await line found with no stalled request");
                end
                finish_handshake();
            end else if (cmd == "C") begin
                code = $fscanf(fd, "%h %h", f0, f1);
                require_fields(code, 2);
                apply_completion(tag_t'(f0), data_t'(f1));
            end else if (cmd == "R") begin
                code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                require_fields(code, 4);
                ret.rdest    = reg_idx_t'(f0);
                ret.has_dest = f1[0];
                ret.tag      = tag_t'(f2);
                ret.data     = data_t'(f3);
                expect_retire(ret);
            end else if (cmd == "F") begin
                apply_flush();
            end else begin
                abort_run("Unknown command in the pattern file");
            end
        end
        $fclose(fd);

        // Quiet tail so that a stray commit still shows up
        repeat (10) @(posedge clk);
        if ((retired_q.size() != 0) || (model_retire_q.size() != 0)) begin
            abort_run("Retirements happened that no pattern line expected");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/rename_pkg.sv
verilog/register_map.sv
verilog/reorder_buffer.sv
verilog/dispatch_ctrl.sv
verilog/rename_core.sv
verif/tb_rename_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_rename_core
./obj_dir/Vtb_rename_core > sim.log 2>&1 || true
cat sim.log
if grep -qF -- '>>> FAIL' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -qF -- '>>> PASS' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== verif/rename_patterns.txt ====
# D rdest has rsrc0 rsrc1 | W rdest has rsrc0 rsrc1 stall | A awaits the stalled dispatch
# C tag data | R rdest has tag data (expected retire) | F flush | all fields in hex
D 1 1 2 3
D 2 1 1 2
D 0 1 1 0
D 3 1 2 0
C 1 000000aa
D 4 1 2 1
C 0 00000011
R 1 1 0 00000011
R 2 1 1 000000aa
D 5 1 1 2
D 3 1 3 0
C 2 00000022
R 0 1 2 00000022
C 3 00000033
R 3 1 3 00000033
D 6 1 3 5
D 0 0 0 0
F
D b 1 3 1
D c 1 b 0
D d 1 5 6
D e 1 0 0
D f 1 0 0
D 10 1 0 0
D 11 1 0 0
D 12 1 c 0
W 13 1 12 0 8
C 1 000000bb
A
R b 1 1 000000bb
C 2 000000cc
R c 1 2 000000cc
D 14 1 c b
